// File: Makefile
TOP := tb_frame_mover

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// File: axil/axil_reader.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module axil_reader (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    req_valid_i,
  input  logic [`CHUNK_IDX_W-1:0] req_idx_i,
  input  logic                    req_last_i,
  output logic                    req_ready_o,
  output frame_pkg::axil_req_t    req_o,
  input  frame_pkg::axil_rsp_t    rsp_i,
  output frame_pkg::chunk_u       chunk_o,
  output logic                    chunk_valid_o,
  output logic                    chunk_last_o,
  input  logic                    chunk_ready_i,
  output logic                    read_err_o
);

  localparam int AW = `AXI_ADDR_W;

  logic          ar_pend_q; // AR presented, not accepted
  logic          r_pend_q; // waiting on R data
  logic          last_q; // flag for the outstanding read
  logic [AW-1:0] addr_q;
  logic          r_fire;

  assign req_ready_o   = !ar_pend_q && !r_pend_q;
  assign chunk_valid_o = r_pend_q && rsp_i.rvalid; // straight from the bus
  assign chunk_o.raw   = rsp_i.rdata;
  assign chunk_last_o  = last_q;
  assign r_fire        = chunk_valid_o && chunk_ready_i;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      ar_pend_q  <= 1'b0;
      r_pend_q   <= 1'b0;
      last_q     <= 1'b0;
      read_err_o <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        ar_pend_q <= 1'b1; // arvalid next cycle
        last_q    <= req_last_i;
      end
      if (ar_pend_q && rsp_i.arready) begin
        ar_pend_q <= 1'b0;
        r_pend_q  <= 1'b1;
      end
      if (r_fire) r_pend_q <= 1'b0;
      read_err_o <= r_fire && (rsp_i.rresp != 2'b00);
    end
  end

  always_ff @(posedge clk_camera) begin
    if (req_valid_i && req_ready_o) addr_q <= AW'({req_idx_i, 4'b0000});
  end

  always_comb begin
    req_o         = '0; // write half comes from the writer
    req_o.araddr  = addr_q;
    req_o.arvalid = ar_pend_q;
    req_o.rready  = r_pend_q && chunk_ready_i; // unstacker back-pressure reaches R
  end

endmodule

// File: axil/axil_writer.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module axil_writer (
  input  logic                  clk_camera,
  input  logic                  recent_reset,
  input  frame_pkg::chunk_req_t chunk_i,
  input  logic                  chunk_valid_i,
  output logic                  chunk_ready_o,
  output frame_pkg::axil_req_t  req_o,
  input  frame_pkg::axil_rsp_t  rsp_i,
  output logic                  write_done_o,
  output logic                  write_err_o
);

  localparam int AW = `AXI_ADDR_W;

  logic                 aw_pend_q; // AW not yet accepted
  logic                 w_pend_q; // W not yet accepted
  logic                 b_pend_q; // waiting on B
  logic [AW-1:0]        addr_q;
  logic [`CHUNK_W-1:0]  data_q;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 b_fire;

  assign aw_fire       = aw_pend_q && rsp_i.awready;
  assign w_fire        = w_pend_q && rsp_i.wready;
  assign b_fire        = b_pend_q && rsp_i.bvalid;
  assign chunk_ready_o = !aw_pend_q && !w_pend_q && !b_pend_q; // one write at a time

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      aw_pend_q    <= 1'b0;
      w_pend_q     <= 1'b0;
      b_pend_q     <= 1'b0;
      write_done_o <= 1'b0;
      write_err_o  <= 1'b0;
    end else begin
      if (chunk_valid_i && chunk_ready_o) begin
        aw_pend_q <= 1'b1; // both channels raised together
        w_pend_q  <= 1'b1;
      end else begin
        if (aw_fire) aw_pend_q <= 1'b0;
        if (w_fire) w_pend_q <= 1'b0;
        // last of AW/W just went through
        if ((aw_pend_q || w_pend_q) && (!aw_pend_q || aw_fire) && (!w_pend_q || w_fire))
          b_pend_q <= 1'b1;
      end
      if (b_fire) b_pend_q <= 1'b0;
      write_done_o <= b_fire;
      write_err_o  <= b_fire && (rsp_i.bresp != 2'b00); // slverr or decerr
    end
  end

  always_ff @(posedge clk_camera) begin
    if (chunk_valid_i && chunk_ready_o) begin
      addr_q <= AW'({chunk_i.idx, 4'b0000}); // 16 bytes per chunk
      data_q <= chunk_i.data.raw;
    end
  end

  always_comb begin
    req_o         = '0; // read half comes from the reader
    req_o.awaddr  = addr_q;
    req_o.awvalid = aw_pend_q;
    req_o.wdata   = data_q;
    req_o.wstrb   = '1;
    req_o.wvalid  = w_pend_q;
    req_o.bready  = b_pend_q;
  end

endmodule

// File: common/frame_cfg.svh
`ifndef FRAME_CFG_SVH
`define FRAME_CFG_SVH

// frame geometry
`define FRAME_W 32 // pixels per line
`define FRAME_H 4 // lines per frame

// chunking of the frame into memory words
`define PIX_PER_CHUNK 8 // rgb565 pixels per 128b word
`define FRAME_CHUNKS 16 // FRAME_W*FRAME_H/PIX_PER_CHUNK
`define CHUNK_IDX_W 4 // log2 of FRAME_CHUNKS
`define CHUNK_W 128 // one axi data beat

// axi byte address, same width the ddr controller takes
`define AXI_ADDR_W 27

// pure red in rgb565
`define ERR_COLOR 16'hF800

`endif

// File: common/frame_pkg.sv
`include "frame_cfg.svh"

package frame_pkg;

  // rgb565 field view, r in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef union packed {
    logic [15:0] raw; // whole word, e.g. an index value
    rgb565_t     rgb; // split into color fields
  } pixel_u;

  // pix[0] lands in bits 15:0
  typedef union packed {
    logic [`CHUNK_W-1:0]                raw;
    pixel_u [`PIX_PER_CHUNK-1:0]        pix;
  } chunk_u;

  typedef struct packed {
    chunk_u                  data;
    logic [`CHUNK_IDX_W-1:0] idx; // chunk position in frame
  } chunk_req_t;

  // master side of the axi4-lite port
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [`CHUNK_W-1:0]    wdata;
    logic [`CHUNK_W/8-1:0]  wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  // slave side
  typedef struct packed {
    logic                awready;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                arready;
    logic [`CHUNK_W-1:0] rdata;
    logic [1:0]          rresp;
    logic                rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic       valid;
    logic       last; // final pixel of the frame
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix_out_t;

endpackage

// File: flist.f
+incdir+common
common/frame_pkg.sv
src/frame_ctrl.sv
src/pattern_stacker.sv
axil/axil_writer.sv
axil/axil_reader.sv
src/pixel_unstacker.sv
src/frame_mover_top.sv
tb/frame_mover_properties.sv
tb/tb_frame_mover.sv

// File: src/frame_ctrl.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module frame_ctrl (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic [1:0]              pattern_sel_i,
  output logic                    start_o,
  output logic [1:0]              pattern_o,
  input  logic                    write_done_i,
  input  logic                    write_err_i,
  output logic                    rd_req_valid_o,
  output logic [`CHUNK_IDX_W-1:0] rd_req_idx_o,
  output logic                    rd_req_last_o,
  input  logic                    rd_req_ready_i,
  input  logic                    read_err_i,
  input  logic                    frame_last_px_i,
  output logic                    frame_done_o,
  output logic                    err_o
);

  localparam logic [`CHUNK_IDX_W-1:0] LAST_IDX = `CHUNK_IDX_W'(`FRAME_CHUNKS - 1);

  typedef enum logic [1:0] {
    S_WRITE,
    S_READ,
    S_DONE
  } state_t;

  state_t                  state_q;
  logic                    kick_q; // frame start still to be issued
  logic [`CHUNK_IDX_W-1:0] wr_cnt_q; // B responses seen so far
  logic [`CHUNK_IDX_W-1:0] rd_idx_q; // next chunk to request
  logic                    rd_fire;

  assign rd_fire        = rd_req_valid_o && rd_req_ready_i;
  assign rd_req_valid_o = (state_q == S_READ);
  assign rd_req_idx_o   = rd_idx_q;
  assign rd_req_last_o  = (rd_idx_q == LAST_IDX);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state_q      <= S_WRITE; // frame begins straight out of reset
      kick_q       <= 1'b1;
      start_o      <= 1'b0;
      pattern_o    <= 2'd0;
      wr_cnt_q     <= '0;
      rd_idx_q     <= '0;
      frame_done_o <= 1'b0;
      err_o        <= 1'b0;
    end else begin
      start_o      <= 1'b0;
      frame_done_o <= 1'b0;
      err_o        <= err_o | write_err_i | read_err_i; // sticky
      if (kick_q) begin
        kick_q    <= 1'b0;
        start_o   <= 1'b1;
        pattern_o <= pattern_sel_i; // held for the whole frame
      end
      case (state_q)
        S_WRITE: begin
          if (write_done_i) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
            if (wr_cnt_q == LAST_IDX) begin
              state_q  <= S_READ; // all chunks are in memory
              rd_idx_q <= '0;
            end
          end
        end
        S_READ: begin
          if (rd_fire) begin
            rd_idx_q <= rd_idx_q + 1'b1;
            if (rd_req_last_o) state_q <= S_DONE;
          end
        end
        default: begin
          // unstacker still draining
          if (frame_last_px_i) begin
            frame_done_o <= 1'b1;
            state_q      <= S_WRITE;
            wr_cnt_q     <= '0;
            kick_q       <= 1'b1; // restart with a fresh snapshot
          end
        end
      endcase
    end
  end

endmodule

// File: src/frame_mover_top.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module frame_mover_top (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic [1:0]           pattern_sel_i,
  output frame_pkg::axil_req_t axil_req_o,
  input  frame_pkg::axil_rsp_t axil_rsp_i,
  output frame_pkg::pix_out_t  pix_o,
  input  logic                 pix_ready_i,
  output logic                 frame_done_o,
  output logic                 err_o
);

  // control
  logic                    start;
  logic [1:0]              pattern;
  logic                    write_done, write_err, read_err;
  logic                    rd_req_valid, rd_req_last, rd_req_ready;
  logic [`CHUNK_IDX_W-1:0] rd_req_idx;
  logic                    frame_last_px;
  // write path
  frame_pkg::chunk_req_t   wr_chunk;
  logic                    wr_chunk_valid, wr_chunk_ready;
  frame_pkg::axil_req_t    wr_req, rd_req;
  // read path
  frame_pkg::chunk_u       rd_chunk;
  logic                    rd_chunk_valid, rd_chunk_last, rd_chunk_ready;

  frame_ctrl u_ctrl (
    .clk_camera, .recent_reset, .pattern_sel_i,
    .start_o(start), .pattern_o(pattern),
    .write_done_i(write_done), .write_err_i(write_err),
    .rd_req_valid_o(rd_req_valid), .rd_req_idx_o(rd_req_idx),
    .rd_req_last_o(rd_req_last), .rd_req_ready_i(rd_req_ready),
    .read_err_i(read_err), .frame_last_px_i(frame_last_px),
    .frame_done_o, .err_o
  );

  pattern_stacker u_stacker (
    .clk_camera, .recent_reset, .start_i(start), .pattern_i(pattern),
    .chunk_o(wr_chunk), .chunk_valid_o(wr_chunk_valid), .chunk_ready_i(wr_chunk_ready)
  );

  axil_writer u_writer (
    .clk_camera, .recent_reset,
    .chunk_i(wr_chunk), .chunk_valid_i(wr_chunk_valid), .chunk_ready_o(wr_chunk_ready),
    .req_o(wr_req), .rsp_i(axil_rsp_i),
    .write_done_o(write_done), .write_err_o(write_err)
  );

  axil_reader u_reader (
    .clk_camera, .recent_reset,
    .req_valid_i(rd_req_valid), .req_idx_i(rd_req_idx), .req_last_i(rd_req_last),
    .req_ready_o(rd_req_ready), .req_o(rd_req), .rsp_i(axil_rsp_i),
    .chunk_o(rd_chunk), .chunk_valid_o(rd_chunk_valid), .chunk_last_o(rd_chunk_last),
    .chunk_ready_i(rd_chunk_ready), .read_err_o(read_err)
  );

  pixel_unstacker u_unstacker (
    .clk_camera, .recent_reset,
    .chunk_i(rd_chunk), .chunk_valid_i(rd_chunk_valid), .chunk_last_i(rd_chunk_last),
    .chunk_ready_o(rd_chunk_ready), .pix_o, .pix_ready_i, .frame_last_px_o(frame_last_px)
  );

  // write channels from the writer, read channels from the reader
  always_comb begin
    axil_req_o         = wr_req;
    axil_req_o.araddr  = rd_req.araddr;
    axil_req_o.arvalid = rd_req.arvalid;
    axil_req_o.rready  = rd_req.rready;
  end

endmodule

// File: src/pattern_stacker.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module pattern_stacker (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic                   start_i,
  input  logic [1:0]             pattern_i,
  output frame_pkg::chunk_req_t  chunk_o,
  output logic                   chunk_valid_o,
  input  logic                   chunk_ready_i
);

  localparam int PIX_IDX_W = $clog2(`FRAME_W * `FRAME_H); // 7
  localparam int X_W       = $clog2(`FRAME_W); // 5
  localparam int SLOT_W    = $clog2(`PIX_PER_CHUNK); // 3
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PIX_PER_CHUNK - 1);
  localparam logic [`CHUNK_IDX_W-1:0] LAST_IDX = `CHUNK_IDX_W'(`FRAME_CHUNKS - 1);

  logic [PIX_IDX_W-1:0]       pix_cnt_q; // running pixel index in frame
  logic [`CHUNK_IDX_W-1:0]    idx_q;
  logic                       building_q; // filling the chunk buffer
  frame_pkg::chunk_u          buf_q;
  frame_pkg::pixel_u          px;
  logic [X_W-1:0]             x;
  logic [PIX_IDX_W-X_W-1:0]   y;
  logic [SLOT_W-1:0]          slot;

  assign x    = pix_cnt_q[X_W-1:0];
  assign y    = pix_cnt_q[PIX_IDX_W-1:X_W];
  assign slot = pix_cnt_q[SLOT_W-1:0];

  always_comb begin
    px.raw = '0;
    case (pattern_i)
      2'd0: px.raw = 16'(pix_cnt_q); // index ramp
      2'd1: px.raw = `ERR_COLOR;
      2'd2: begin
        px.rgb.r = 5'(x);
        px.rgb.g = 6'({y, 4'b0000}); // y * 16
        px.rgb.b = 5'(5'd31 - 5'(x));
      end
      default: px.raw = '1; // white
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      building_q    <= 1'b0;
      chunk_valid_o <= 1'b0;
      pix_cnt_q     <= '0;
      idx_q         <= '0;
    end else if (start_i) begin
      building_q    <= 1'b1;
      chunk_valid_o <= 1'b0;
      pix_cnt_q     <= '0;
      idx_q         <= '0;
    end else begin
      if (building_q) begin
        pix_cnt_q <= pix_cnt_q + 1'b1;
        if (slot == LAST_SLOT) begin
          building_q    <= 1'b0;
          chunk_valid_o <= 1'b1; // eighth pixel in
        end
      end
      if (chunk_valid_o && chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
        idx_q         <= idx_q + 1'b1;
        building_q    <= (idx_q != LAST_IDX); // stop after the frame
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (building_q) buf_q.pix[slot] <= px;
  end

  always_comb begin
    chunk_o.data = buf_q;
    chunk_o.idx  = idx_q;
  end

endmodule

// File: src/pixel_unstacker.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module pixel_unstacker (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  frame_pkg::chunk_u    chunk_i,
  input  logic                 chunk_valid_i,
  input  logic                 chunk_last_i,
  output logic                 chunk_ready_o,
  output frame_pkg::pix_out_t  pix_o,
  input  logic                 pix_ready_i,
  output logic                 frame_last_px_o
);

  localparam int SLOT_W = $clog2(`PIX_PER_CHUNK);
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`PIX_PER_CHUNK - 1);

  frame_pkg::chunk_u  buf_q; // shifts down one pixel per transfer
  frame_pkg::pixel_u  px;
  logic [SLOT_W-1:0]  cnt_q; // pixel position within chunk
  logic               full_q;
  logic               last_q; // chunk closes the frame
  logic               pix_fire;
  logic               chunk_fire;

  assign px         = buf_q.pix[0];
  assign pix_fire   = full_q && pix_ready_i;
  // next chunk taken as the eighth pixel leaves
  assign chunk_ready_o = !full_q || (pix_ready_i && (cnt_q == LAST_SLOT));
  assign chunk_fire = chunk_valid_i && chunk_ready_o;

  always_comb begin
    pix_o.valid = full_q;
    pix_o.last  = last_q && (cnt_q == LAST_SLOT);
    pix_o.r     = {px.rgb.r, 3'b000}; // zero fill low bits
    pix_o.g     = {px.rgb.g, 2'b00};
    pix_o.b     = {px.rgb.b, 3'b000};
  end

  assign frame_last_px_o = pix_fire && pix_o.last;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
      last_q <= 1'b0;
    end else if (chunk_fire) begin
      full_q <= 1'b1;
      cnt_q  <= '0;
      last_q <= chunk_last_i;
    end else if (pix_fire) begin
      if (cnt_q == LAST_SLOT) begin
        full_q <= 1'b0; // drained, nothing waiting
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (chunk_fire) begin
      buf_q <= chunk_i;
    end else if (pix_fire) begin
      buf_q.raw <= buf_q.raw >> 16; // bring up the next pixel
    end
  end

endmodule

// File: tb/frame_mover_properties.sv
`timescale 1ns/10ps

module frame_mover_properties (
  input logic                 clk_camera,
  input logic                 recent_reset,
  input frame_pkg::axil_req_t axil_req_o,
  input frame_pkg::axil_rsp_t axil_rsp_i,
  input frame_pkg::pix_out_t  pix_o,
  input logic                 pix_ready_i,
  input logic                 frame_done_o,
  input logic                 err_o
);

  logic px_sent_q; // a pixel left since the last frame end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) px_sent_q <= 1'b0;
    else if (frame_done_o) px_sent_q <= 1'b0;
    else if (pix_o.valid && pix_ready_i) px_sent_q <= 1'b1;
  end

  a_aw_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    axil_req_o.awvalid && !axil_rsp_i.awready |=>
      axil_req_o.awvalid && $stable(axil_req_o.awaddr))
    else $error("awvalid dropped or awaddr moved before awready");

  a_w_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    axil_req_o.wvalid && !axil_rsp_i.wready |=> axil_req_o.wvalid && $stable(axil_req_o.wdata))
    else $error("wvalid dropped or wdata moved before wready");

  a_ar_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    axil_req_o.arvalid && !axil_rsp_i.arready |=>
      axil_req_o.arvalid && $stable(axil_req_o.araddr))
    else $error("arvalid dropped or araddr moved before arready");

  // pixel held whole, last flag included
  a_pix_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    pix_o.valid && !pix_ready_i |=> pix_o.valid && $stable(pix_o))
    else $error("pixel changed while pix_ready_i was low");

  a_done_after_px: assert property (@(posedge clk_camera) disable iff (recent_reset)
    $rose(frame_done_o) |-> (err_o || px_sent_q))
    else $error("frame_done_o rose with no pixel sent");

endmodule

// File: tb/tb_frame_mover.sv
`timescale 1ns/10ps
`include "frame_cfg.svh"

module tb_frame_mover;

  localparam int FRAME_PIX   = `FRAME_W * `FRAME_H; // 128 pixels
  localparam int FRAME_LIMIT = 4 * 600; // cycles allowed for one frame
  localparam int RUN_LIMIT   = 4 * 600 * 6; // whole run

  logic                   clk_camera;
  logic                   recent_reset;
  logic [1:0]             pattern_sel_i;
  frame_pkg::axil_req_t   axil_req_o;
  frame_pkg::axil_rsp_t   axil_rsp_i;
  frame_pkg::pix_out_t    pix_o;
  logic                   pix_ready_i;
  logic                   frame_done_o;
  logic                   err_o;

  logic [`CHUNK_W-1:0]    mem [`FRAME_CHUNKS]; // slave memory of one chunk per word
  logic [31:0]            lfsr_q;
  logic                   axi_stall; // random ready/valid gaps on the bus
  logic                   pix_stall; // random pix_ready_i
  int                     slverr_b; // B response given SLVERR or -1
  int                     b_seen;
  logic                   model_rst; // reset as the DUT sampled it
  logic                   aw_got, w_got, b_on, ar_got, r_on;
  logic [`AXI_ADDR_W-1:0] aw_addr, ar_addr;
  logic [`CHUNK_W-1:0]    w_data;
  logic [24:0]            px_q [$]; // {last, r, g, b} per transfer
  int                     px_rd; // next pixel to check
  int                     done_cnt;
  logic                   last_px_prev; // final pixel went out at the previous edge

  frame_mover_top DUT (
    .clk_camera, .recent_reset, .pattern_sel_i, .axil_req_o, .axil_rsp_i,
    .pix_o, .pix_ready_i, .frame_done_o, .err_o
  );

  bind frame_mover_top frame_mover_properties u_props (
    .clk_camera(clk_camera), .recent_reset(recent_reset), .axil_req_o(axil_req_o),
    .axil_rsp_i(axil_rsp_i), .pix_o(pix_o), .pix_ready_i(pix_ready_i),
    .frame_done_o(frame_done_o), .err_o(err_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #5 clk_camera = ~clk_camera;
  end

  always @(posedge clk_camera) model_rst <= recent_reset;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic logic allow(input logic stall);
    return stall ? rand_bit() : 1'b1; // no lfsr step without a stall
  endfunction

  // rgb565 value of pixel idx for each pattern
  function automatic logic [15:0] pixel_rule(input logic [1:0] pat, input int idx);
    int x;
    int y;
    x = idx % `FRAME_W;
    y = idx / `FRAME_W;
    case (pat)
      2'd0: return 16'(idx);
      2'd1: return `ERR_COLOR;
      2'd2: return {5'(x), 6'(y * 16), 5'(31 - x)};
      default: return 16'hFFFF;
    endcase
  endfunction

  function automatic logic [`CHUNK_W-1:0] chunk_rule(input logic [1:0] pat, input int c);
    logic [`CHUNK_W-1:0] d;
    for (int k = 0; k < `PIX_PER_CHUNK; k++)
      d[k*16 +: 16] = pixel_rule(pat, c * `PIX_PER_CHUNK + k); // pixel 0 lowest
    return d;
  endfunction

  task automatic expect_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // axi4-lite slave and pixel sink driven on the falling edge
  initial begin
    lfsr_q       = 32'hda62;
    axil_rsp_i   = '0;
    pix_ready_i  = 1'b0;
    done_cnt     = 0;
    b_seen       = 0;
    last_px_prev = 1'b0;
    {aw_got, w_got, b_on, ar_got, r_on} = '0;
    aw_addr = '0;
    ar_addr = '0;
    w_data  = '0;
    for (int i = 0; i < `FRAME_CHUNKS; i++) mem[4'(i)] = {8{16'hA500 | 16'(i)}};
    forever begin
      @(negedge clk_camera);
      if (model_rst) begin
        {aw_got, w_got, b_on, ar_got, r_on} = '0;
        b_seen       = 0;
        axil_rsp_i   = '0;
        last_px_prev = 1'b0;
        px_q.delete();
      end else begin
        axil_rsp_i.awready = !aw_got && !b_on && allow(axi_stall);
        axil_rsp_i.wready  = !w_got && !b_on && allow(axi_stall);
        axil_rsp_i.arready = !ar_got && allow(axi_stall);
        if (aw_got && w_got && !b_on && allow(axi_stall)) begin
          mem[aw_addr[7:4]] = w_data; // 16 bytes per word
          axil_rsp_i.bresp  = (b_seen == slverr_b) ? 2'b10 : 2'b00;
          b_seen++;
          b_on = 1'b1;
        end
        if (ar_got && !r_on && allow(axi_stall)) begin
          axil_rsp_i.rdata = mem[ar_addr[7:4]];
          axil_rsp_i.rresp = 2'b00;
          r_on = 1'b1;
        end
        axil_rsp_i.bvalid = b_on; // held until bready
        axil_rsp_i.rvalid = r_on;
      end
      pix_ready_i = allow(pix_stall);
      #1; // settled values transfer at the next rising edge
      if (!model_rst) begin
        if (axil_req_o.awvalid && axil_rsp_i.awready) begin
          aw_addr = axil_req_o.awaddr;
          aw_got  = 1'b1;
          expect_eq("awaddr", 128'({aw_addr[`AXI_ADDR_W-1:8], aw_addr[3:0]}), '0);
        end
        if (axil_req_o.wvalid && axil_rsp_i.wready) begin
          w_data = axil_req_o.wdata;
          w_got  = 1'b1;
          expect_eq("wstrb", 128'(axil_req_o.wstrb), 128'(16'hFFFF));
        end
        if (axil_req_o.bready && b_on) {aw_got, w_got, b_on} = '0;
        if (axil_req_o.arvalid && axil_rsp_i.arready) begin
          ar_addr = axil_req_o.araddr;
          ar_got  = 1'b1;
          expect_eq("araddr", 128'({ar_addr[`AXI_ADDR_W-1:8], ar_addr[3:0]}), '0);
        end
        if (axil_req_o.rready && r_on) {ar_got, r_on} = '0;
        if (pix_o.valid && pix_ready_i) px_q.push_back({pix_o.last, pix_o.r, pix_o.g, pix_o.b});
        // one pulse right after the final pixel
        expect_eq("frame_done_o", 128'(frame_done_o), 128'(last_px_prev));
        if (frame_done_o) done_cnt++;
        last_px_prev = pix_o.valid && pix_ready_i && pix_o.last;
      end
    end
  end

  task automatic apply_reset(input logic [1:0] pat, input logic a_stall, input logic p_stall,
                             input int err_b);
    @(posedge clk_camera);
    axi_stall = a_stall;
    pix_stall = p_stall;
    slverr_b  = err_b;
    @(negedge clk_camera);
    recent_reset  = 1'b1;
    pattern_sel_i = pat; // snapshot comes right after reset
    repeat (3) @(negedge clk_camera);
    recent_reset = 1'b0;
    px_rd        = 0;
  endtask

  task automatic wait_frame();
    int start_cnt;
    int n;
    start_cnt = done_cnt;
    n = 0;
    while (done_cnt == start_cnt) begin
      @(posedge clk_camera);
      n++;
      if (n > FRAME_LIMIT) begin
        $display("no frame_done_o within %0d cycles", FRAME_LIMIT);
        $display("TB FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic wait_pixels(input int count);
    int n;
    n = 0;
    while (px_q.size() < count) begin
      @(posedge clk_camera);
      n++;
      if (n > FRAME_LIMIT) begin
        $display("only %0d of %0d pixels arrived", px_q.size(), count);
        $display("TB FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic check_frame(input logic [1:0] pat);
    logic [15:0] p;
    logic [24:0] exp;
    expect_eq("pixel count", 128'(px_q.size() - px_rd), 128'(FRAME_PIX));
    for (int i = 0; i < FRAME_PIX; i++) begin
      p   = pixel_rule(pat, i);
      exp = {i == FRAME_PIX - 1, p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
      expect_eq($sformatf("pixel %0d", i), 128'(px_q[px_rd]), 128'(exp));
      px_rd++;
    end
  endtask

  task automatic check_idle();
    #1; // no rising edge yet since reset release
    expect_eq("awvalid", 128'(axil_req_o.awvalid), '0);
    expect_eq("wvalid", 128'(axil_req_o.wvalid), '0);
    expect_eq("bready", 128'(axil_req_o.bready), '0);
    expect_eq("arvalid", 128'(axil_req_o.arvalid), '0);
    expect_eq("rready", 128'(axil_req_o.rready), '0);
    expect_eq("pix_o.valid", 128'(pix_o.valid), '0);
    expect_eq("frame_done_o", 128'(frame_done_o), '0);
    expect_eq("err_o", 128'(err_o), '0);
  endtask

  task automatic test_index_ramp();
    apply_reset(2'd0, 1'b0, 1'b0, -1);
    wait_frame();
    check_frame(2'd0);
    expect_eq("err_o", 128'(err_o), '0);
  endtask

  task automatic test_stalled_gradient();
    apply_reset(2'd2, 1'b1, 1'b1, -1);
    wait_frame();
    check_frame(2'd2);
    for (int c = 0; c < `FRAME_CHUNKS; c++)
      expect_eq($sformatf("mem[%0d]", c), mem[4'(c)], chunk_rule(2'd2, c));
  endtask

  task automatic test_pattern_switch();
    apply_reset(2'd1, 1'b0, 1'b1, -1);
    while (b_seen < 4) @(posedge clk_camera);
    @(negedge clk_camera);
    pattern_sel_i = 2'd3; // lands while chunks are still being written
    wait_frame();
    check_frame(2'd1);
    wait_frame();
    check_frame(2'd3);
  endtask

  task automatic test_solid_colors();
    apply_reset(2'd1, 1'b1, 1'b0, -1);
    wait_frame();
    check_frame(2'd1);
    apply_reset(2'd3, 1'b1, 1'b1, -1);
    wait_frame();
    check_frame(2'd3);
  endtask

  task automatic test_write_error();
    apply_reset(2'd0, 1'b1, 1'b0, 5); // sixth B gets SLVERR
    expect_eq("err_o", 128'(err_o), '0);
    wait_frame();
    check_frame(2'd0);
    expect_eq("err_o", 128'(err_o), 128'(1'b1));
    wait_frame();
    check_frame(2'd0);
    expect_eq("err_o", 128'(err_o), 128'(1'b1)); // sticky
  endtask

  task automatic test_mid_reset();
    apply_reset(2'd2, 1'b1, 1'b1, -1);
    wait_pixels(20);
    apply_reset(2'd0, 1'b1, 1'b1, -1);
    check_idle();
    wait_frame();
    check_frame(2'd0);
  endtask

  initial begin
    recent_reset  = 1'b1;
    pattern_sel_i = 2'd0;
    axi_stall     = 1'b0;
    pix_stall     = 1'b0;
    slverr_b      = -1;
    px_rd         = 0;
    test_index_ramp();
    test_stalled_gradient();
    test_pattern_switch();
    test_solid_colors();
    test_write_error();
    test_mid_reset();
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (RUN_LIMIT) @(posedge clk_camera);
    $display("watchdog expired after %0d cycles, the tests did not finish", RUN_LIMIT);
    $display("TB FAILED");
    $fatal(1);
  end

endmodule
